//--- flist.f
logic/uart_pkg.sv
logic/uart_rx.sv
logic/rx_fifo.sv
logic/frame_checker.sv
logic/uart_frame_top.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_frame_top.sv

//--- logic/frame_checker.sv
// ----------------------------------------
// Frame is sync, FRAME_LEN payload bytes, then the sum modulo 256.
// ----------------------------------------

`timescale 1ns/1ps

module frame_checker #(
    parameter int FRAME_LEN = 4
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       hold,
    input  logic                       empty,
    input  uart_pkg::byte_t            rd_data,
    output logic                       pop,
    output logic                       frame_done,
    output uart_pkg::frame_status_t    frame_status
);

    // Wide enough for FRAME_LEN of 1.
    localparam int CNT_W = $clog2(FRAME_LEN + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    typedef enum logic [1:0] {
        HUNT,
        PAYLOAD,
        CHECK
    } chk_state_t;

    chk_state_t    state;
    cnt_t          cnt;
    uart_pkg::sum_t sum;

    // Consume a byte whenever one is there and not held off.
    assign pop = !empty && !hold;

    // ----------------------------------------
    // Frame state machine
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= HUNT;
            cnt   <= '0;
        end else if (pop) begin
            case (state)
                // Anything but sync is discarded.
                HUNT: begin
                    if (rd_data == uart_pkg::SYNC_BYTE) begin
                        state <= PAYLOAD;
                        cnt   <= '0;
                    end
                end
                PAYLOAD: begin
                    if (cnt == cnt_t'(FRAME_LEN - 1)) begin
                        state <= CHECK;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // Check byte closes the frame.
                CHECK: state <= HUNT;
                default: state <= HUNT;
            endcase
        end
    end

    // Sum starts fresh at sync and wraps.
    always_ff @(posedge clk) begin
        if (pop && state == HUNT) begin
            sum <= '0;
        end else if (pop && state == PAYLOAD) begin
            sum <= sum + rd_data;
        end
    end

    // ----------------------------------------
    // Result
    // ----------------------------------------

    // Pulse one cycle after the check byte is popped.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= pop && (state == CHECK);
        end
    end

    // Status holds until the next frame completes.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_status <= '0;
        end else if (pop && state == CHECK) begin
            frame_status.ok  <= (rd_data == sum);
            frame_status.sum <= sum;
        end
    end

endmodule

//--- logic/rx_fifo.sv
// ----------------------------------------
// DEPTH must be a power of two, at least 2.
// Head byte is shown on rd_data whenever empty is low.
// ----------------------------------------

`timescale 1ns/1ps

module rx_fifo #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               rx_valid,
    input  uart_pkg::byte_t    rx_data,
    output logic               rx_read,
    input  logic               pop,
    output logic               empty,
    output uart_pkg::byte_t    rd_data
);

    localparam int ADDR_W = $clog2(DEPTH);

    // Pointers carry one wrap bit above the address.
    typedef logic [ADDR_W:0] ptr_t;

    uart_pkg::byte_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic full;

    // ----------------------------------------
    // Flags
    // ----------------------------------------

    // Same address, different wrap bit means full.
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
                && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // Take the receiver's byte whenever there is room.
    assign rx_read = rx_valid && !full;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rx_read) begin
            mem[wr_ptr[ADDR_W-1:0]] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
        end else if (rx_read) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Pop is only legal while not empty.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_ptr <= '0;
        end else if (pop && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Show-ahead read of the oldest entry.
    assign rd_data = mem[rd_ptr[ADDR_W-1:0]];

endmodule

//--- logic/uart_frame_top.sv
// ----------------------------------------
// Sender must wait for rts low before each start bit.
// ----------------------------------------

`timescale 1ns/1ps

module uart_frame_top #(
    parameter int CLK_HZ     = 50_000_000,
    parameter int BIT_RATE   = 9600,
    parameter int STOP_BITS  = 1,
    parameter int FIFO_DEPTH = 4,
    parameter int FRAME_LEN  = 4
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       rxd,
    input  logic                       hold,
    output logic                       rts,
    output logic                       frame_done,
    output uart_pkg::frame_status_t    frame_status
);

    // Receiver to FIFO.
    logic            rx_valid;
    logic            rx_read;
    uart_pkg::byte_t rx_data;

    // FIFO to checker.
    logic            empty;
    logic            pop;
    uart_pkg::byte_t rd_data;

    // ----------------------------------------
    // Receive path
    // ----------------------------------------

    uart_rx #(
        .CLK_HZ    (CLK_HZ),
        .BIT_RATE  (BIT_RATE),
        .STOP_BITS (STOP_BITS)
    ) rx0 (
        .clk      (clk),
        .resetn   (resetn),
        .rxd      (rxd),
        .rts      (rts),
        .rx_read  (rx_read),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    // Burst buffer, its full state back-pressures the receiver.
    rx_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk      (clk),
        .resetn   (resetn),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_read  (rx_read),
        .pop      (pop),
        .empty    (empty),
        .rd_data  (rd_data)
    );

    frame_checker #(
        .FRAME_LEN (FRAME_LEN)
    ) chk0 (
        .clk          (clk),
        .resetn       (resetn),
        .hold         (hold),
        .empty        (empty),
        .rd_data      (rd_data),
        .pop          (pop),
        .frame_done   (frame_done),
        .frame_status (frame_status)
    );

endmodule

//--- logic/uart_pkg.sv
// ----------------------------------------
// Shared types for the UART frame receive path.
// The byte width is fixed at 8 bits and is not a parameter.
// ----------------------------------------

package uart_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Bits per UART character.
    localparam int DATA_BITS = 8;

    // One received byte.
    typedef logic [DATA_BITS-1:0] byte_t;

    // Running payload sum, wraps modulo 256.
    typedef logic [7:0] sum_t;

    // ----------------------------------------
    // Framing
    // ----------------------------------------

    // First byte of every frame.
    localparam byte_t SYNC_BYTE = 8'hA5;

    // Result of one frame check.
    typedef struct packed {
        logic ok;
        sum_t sum;
    } frame_status_t;

endpackage

//--- logic/uart_rx.sv
// ----------------------------------------
// Needs CLK_HZ / BIT_RATE >= 2; bytes with a low stop bit are dropped.
// With several stop bits each is checked and valid rises in the last one.
// ----------------------------------------

`timescale 1ns/1ps

module uart_rx #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int BIT_RATE  = 9600,
    parameter int STOP_BITS = 1
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               rxd,
    output logic               rts,
    input  logic               rx_read,
    output logic               rx_valid,
    output uart_pkg::byte_t    rx_data
);

    // ----------------------------------------
    // Bit timing
    // ----------------------------------------

    // Clock cycles in one bit period.
    localparam int CYCLES_PER_BIT = CLK_HZ / BIT_RATE;
    localparam int CNT_W = $clog2(CYCLES_PER_BIT);
    // Index counts data bits, then stop bits.
    localparam int IDX_MAX = (uart_pkg::DATA_BITS > STOP_BITS) ? uart_pkg::DATA_BITS : STOP_BITS;
    localparam int IDX_W = $clog2(IDX_MAX);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        STOP,
        READY
    } rx_state_t;

    rx_state_t state;
    rx_state_t state_d;

    logic [1:0]      rxd_sync;
    logic            line;
    cnt_t            cnt;
    idx_t            idx;
    logic            bit_mid;
    logic            bit_end;
    uart_pkg::byte_t shreg;

    // Two-flop synchroniser, line idles high.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    assign line = rxd_sync[1];

    // Sample point and bit boundary.
    assign bit_mid = (cnt == cnt_t'(CYCLES_PER_BIT / 2));
    assign bit_end = (cnt == cnt_t'(CYCLES_PER_BIT - 1));

    // Counter idles at zero and restarts at each bit boundary.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (state == IDLE || state == READY || bit_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_comb begin
        state_d = state;
        case (state)
            // Falling edge marks a start bit.
            IDLE: begin
                if (!line) begin
                    state_d = START;
                end
            end
            // A start bit that is high at mid-bit was a glitch.
            START: begin
                if (bit_mid && line) begin
                    state_d = IDLE;
                end else if (bit_end) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                if (bit_end && idx == idx_t'(uart_pkg::DATA_BITS - 1)) begin
                    state_d = STOP;
                end
            end
            // Low stop bit drops the byte.
            STOP: begin
                if (bit_mid) begin
                    if (!line) begin
                        state_d = IDLE;
                    end else if (idx == idx_t'(STOP_BITS - 1)) begin
                        state_d = READY;
                    end
                end
            end
            // Hold the byte until the FIFO takes it.
            READY: begin
                if (rx_read) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    // Bit index clears on every state change.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            idx <= '0;
        end else if (state_d != state) begin
            idx <= '0;
        end else if ((state == DATA || state == STOP) && bit_end) begin
            idx <= idx + 1'b1;
        end
    end

    // LSB arrives first, shift in from the top.
    always_ff @(posedge clk) begin
        if (state == DATA && bit_mid) begin
            shreg <= {line, shreg[uart_pkg::DATA_BITS-1:1]};
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // Active low, ready only while idle or in the start bit.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rts <= 1'b1;
        end else begin
            rts <= !(state_d == IDLE || state_d == START);
        end
    end

    assign rx_valid = (state == READY);
    assign rx_data  = shreg;

endmodule

//--- testbench/tb_clock_gen.sv
// ----------------------------------------
// Free-running clock, starts low at time zero.
// ----------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // Half period per toggle.
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

//--- testbench/tb_uart_frame_top.sv
// ----------------------------------------
// Runs at 8 clocks per bit. The sender obeys rts before every start bit.
// ----------------------------------------

`timescale 1ns/1ps

module tb_uart_frame_top;

    localparam int CYCLES_PER_BIT = 8;
    localparam int GAP_BITS       = 2;
    localparam int FRAME_LEN      = 4;
    localparam int NUM_ENTRIES    = 7;
    localparam int RTS_TIMEOUT    = 2000;
    localparam int DONE_TIMEOUT   = 4000;
    localparam int HOLD_CYCLES    = 800;

    // One row of the stimulus table.
    typedef struct packed {
        logic [1:0] n_junk;
        logic [7:0] junk0;
        logic [7:0] junk1;
        logic [7:0] salt;
        logic       bad_check;
        logic       bad_stop;
        logic       use_hold;
    } entry_t;

    logic                    clk;
    logic                    resetn;
    logic                    rxd;
    logic                    hold;
    logic                    rts;
    logic                    frame_done;
    uart_pkg::frame_status_t frame_status;

    entry_t      entries [NUM_ENTRIES];
    logic [7:0]  payload [FRAME_LEN];
    logic [31:0] rng;
    int          errors = 0;
    int          done_count = 0;
    int          hold_base;

    tb_clock_gen #(.PERIOD_NS(8.0)) clk0 (.clk(clk));

    uart_frame_top #(
        .CLK_HZ     (125000000),
        .BIT_RATE   (15625000),
        .STOP_BITS  (1),
        .FIFO_DEPTH (4),
        .FRAME_LEN  (FRAME_LEN)
    ) dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .rxd          (rxd),
        .hold         (hold),
        .rts          (rts),
        .frame_done   (frame_done),
        .frame_status (frame_status)
    );

    // Count every frame pulse from time zero, reset included.
    always @(posedge clk) begin
        if (frame_done) begin
            done_count <= done_count + 1;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // 32-bit xorshift step.
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    // One UART character, LSB first, after rts allows it.
    task automatic send_byte(input logic [7:0] value, input logic stop_level);
        int waited;
        int i;
        waited = 0;
        while (rts !== 1'b0 && waited < RTS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rts !== 1'b0) begin
            $display("Timed out at %0t ns waiting for rts to go low", $time);
            errors++;
        end
        rxd = 1'b0;
        repeat (CYCLES_PER_BIT) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = value[i];
            repeat (CYCLES_PER_BIT) @(negedge clk);
        end
        rxd = stop_level;
        repeat (CYCLES_PER_BIT) @(negedge clk);
        // Idle gap also lets a dropped byte's false start settle.
        rxd = 1'b1;
        repeat (GAP_BITS * CYCLES_PER_BIT) @(negedge clk);
    endtask

    task automatic send_frame(input entry_t e, input logic [7:0] check_byte);
        int i;
        if (e.n_junk > 0) send_byte(e.junk0, 1'b1);
        if (e.n_junk > 1) send_byte(e.junk1, 1'b1);
        // A sync value with a bad stop bit must not open a frame.
        if (e.bad_stop) send_byte(uart_pkg::SYNC_BYTE, 1'b0);
        send_byte(uart_pkg::SYNC_BYTE, 1'b1);
        for (i = 0; i < FRAME_LEN; i++) begin
            send_byte(payload[i], 1'b1);
        end
        send_byte(check_byte, 1'b1);
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    task automatic load_entries();
        entries[0] = '{2'd0, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0};
        entries[1] = '{2'd0, 8'h00, 8'h00, 8'h11, 1'b1, 1'b0, 1'b0};
        entries[2] = '{2'd2, 8'h3C, 8'hFF, 8'h22, 1'b0, 1'b0, 1'b0};
        entries[3] = '{2'd0, 8'h00, 8'h00, 8'h33, 1'b0, 1'b1, 1'b0};
        entries[4] = '{2'd0, 8'h00, 8'h00, 8'h44, 1'b0, 1'b0, 1'b1};
        entries[5] = '{2'd1, 8'h5A, 8'h00, 8'h55, 1'b0, 1'b0, 1'b0};
        entries[6] = '{2'd1, 8'h00, 8'h00, 8'h66, 1'b1, 1'b0, 1'b1};
    endtask

    initial begin
        int         n;
        int         i;
        int         waited;
        logic [7:0] exp_sum;
        logic [7:0] check_byte;
        resetn = 1'b0;
        rxd    = 1'b1;
        hold   = 1'b0;
        rng    = 32'd59;
        load_entries();
        repeat (5) @(negedge clk);
        check_equal(rts, 1'b1, "rts after reset");
        check_equal(frame_done, 1'b0, "frame_done level during reset");
        check_equal(done_count, 0, "frame_done during reset");
        resetn = 1'b1;
        repeat (4) @(negedge clk);
        for (n = 0; n < NUM_ENTRIES; n++) begin
            // Payload and expected sum from the modulo-256 rule.
            rng = rng ^ {24'd0, entries[n].salt};
            exp_sum = 8'h00;
            for (i = 0; i < FRAME_LEN; i++) begin
                rng = xorshift32(rng);
                payload[i] = rng[7:0];
                exp_sum = exp_sum + rng[7:0];
            end
            check_byte = entries[n].bad_check ? exp_sum + 8'd1 : exp_sum;
            check_equal(done_count, n, "frame count before frame");
            if (entries[n].use_hold) begin
                hold = 1'b1;
                fork
                    send_frame(entries[n], check_byte);
                    begin
                        hold_base = done_count;
                        repeat (HOLD_CYCLES) @(negedge clk);
                        check_equal(rts, 1'b1, "rts while FIFO full under hold");
                        check_equal(done_count, hold_base, "frame_done under hold");
                        hold = 1'b0;
                    end
                join
            end else begin
                send_frame(entries[n], check_byte);
            end
            waited = 0;
            while (done_count <= n && waited < DONE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (done_count <= n) begin
                $display("Timed out at %0t ns waiting for frame_done of entry %0d", $time, n);
                errors++;
            end
            check_equal(done_count, n + 1, "frame count after frame");
            check_equal(frame_status.ok, !entries[n].bad_check, "frame ok");
            check_equal(frame_status.sum, exp_sum, "frame sum");
        end
        // No stray pulse may follow the last frame.
        repeat (50) @(negedge clk);
        check_equal(done_count, NUM_ENTRIES, "total frame_done pulses");
        $display("Errors: %0d, frames reported: %0d", errors, done_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
